//--- design/ddr_axi_pkg.sv
`default_nettype none

// ------------------------------
// AXI4 bus side of the tester
// ------------------------------
package ddr_axi_pkg;

	// bus widths, sim build uses a 64 bit data path
	localparam int AXI_DATA_W = 64;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam int AXI_ADDR_W = 33;
	localparam int AXI_RESP_W = 2;

	// fixed burst shape, incrementing
	// the slave side assumes this, no len/size/burst on the bus
	localparam int BURST_BEATS = 4;
	localparam int BEAT_CNT_W  = $clog2(BURST_BEATS);
	localparam int BEAT_LSB    = $clog2(AXI_STRB_W);
	localparam int BURST_BYTES = BURST_BEATS * AXI_STRB_W;
	// region addresses are aligned to one burst
	localparam int BURST_LSB   = $clog2(BURST_BYTES);

	// only OKAY counts as good, anything else is an error
	localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;

	// controller address map
	localparam int DDR_CS_W   = 1;
	localparam int DDR_ROW_W  = 17;
	localparam int DDR_BANK_W = 3;
	localparam int DDR_COL_W  = 10;
	localparam int DDR_DP_W   = 2;

	// one address word, two readings
	// flat byte address for stepping, fields for the array index
	typedef union packed {
		logic [AXI_ADDR_W-1:0] flat;
		struct packed {
			logic [DDR_CS_W-1:0]   cs;
			logic [DDR_ROW_W-1:0]  row;
			logic [DDR_BANK_W-1:0] bank;
			logic [DDR_COL_W-1:0]  col;
			logic [DDR_DP_W-1:0]   dp;
		} fld;
	} ddr_addr_t;

endpackage

`default_nettype wire

//--- design/mem_test_pkg.sv
`default_nettype none

// ------------------------------
// tester register map and pattern
// ------------------------------
package mem_test_pkg;

	// register port
	localparam int REG_ADDR_W = 3;
	localparam int REG_DATA_W = 32;

	// register indices
	localparam logic [REG_ADDR_W-1:0] REG_CTRL      = 3'd0;
	localparam logic [REG_ADDR_W-1:0] REG_START     = 3'd1;
	localparam logic [REG_ADDR_W-1:0] REG_STOP      = 3'd2;
	localparam logic [REG_ADDR_W-1:0] REG_SEED      = 3'd3;
	localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 3'd4;
	localparam logic [REG_ADDR_W-1:0] REG_FAIL_ADDR = 3'd5;
	localparam logic [REG_ADDR_W-1:0] REG_BURSTS    = 3'd6;

	// ctrl: write 1 to kick off a test
	localparam int CTRL_START_BIT = 0;

	// status bit positions
	localparam int STAT_RUN_BIT  = 0;
	localparam int STAT_DONE_BIT = 1;
	localparam int STAT_FAIL_BIT = 2;

	// pattern rule, beat at byte address A:
	//   upper half = A[31:0] ^ seed
	//   lower half = ~A[31:0]
	localparam int PAT_HALF_W = 32;
	localparam int SEED_W     = 32;

endpackage

`default_nettype wire

//--- design/mem_test_regs.sv
`timescale 1ns/1ns
`default_nettype none

module mem_test_regs
	import ddr_axi_pkg::*, mem_test_pkg::*;
(
	input  wire                    iACLK,
	input  wire                    iARST,
	// controller calibration finished
	input  wire                    i_cfg_done,
	// four-phase register port
	input  wire                    i_reg_req,
	input  wire                    i_reg_wr,
	input  wire [REG_ADDR_W-1:0]   i_reg_addr,
	input  wire [REG_DATA_W-1:0]   i_reg_wdata,
	output logic                   o_reg_ack,
	output logic [REG_DATA_W-1:0]  o_reg_rdata,
	// to checker
	output logic                   o_chk_start,
	output logic [AXI_ADDR_W-1:0]  o_chk_start_addr,
	output logic [AXI_ADDR_W-1:0]  o_chk_stop_addr,
	output logic [SEED_W-1:0]      o_chk_seed,
	// from checker
	input  wire                    i_chk_run,
	input  wire                    i_chk_done,
	input  wire                    i_chk_fail,
	input  wire [AXI_ADDR_W-1:0]   i_chk_fail_addr,
	input  wire [REG_DATA_W-1:0]   i_chk_burst_count
);

	logic                  access;
	logic [REG_DATA_W-1:0] status_word;
	logic [REG_DATA_W-1:0] rd_mux;

	// ------------------------------
	// handshake
	// ------------------------------
	// one access per req, taken on the edge that raises ack
	assign access = i_reg_req && !o_reg_ack;

	always_ff @(posedge iACLK)
	begin
		if (iARST)
		begin
			o_reg_ack        <= 1'b0;
			o_chk_start      <= 1'b0;
			o_chk_start_addr <= '0;
			o_chk_stop_addr  <= '0;
			o_chk_seed       <= '0;
		end
		else
		begin
			// start is a single cycle pulse
			o_chk_start <= 1'b0;
			if (access)
			begin
				o_reg_ack <= 1'b1;
				if (i_reg_wr)
				begin
					case (i_reg_addr)
						// no start before calibration is done
						REG_CTRL:  o_chk_start <= i_reg_wdata[CTRL_START_BIT] && i_cfg_done;
						// burst offset bits dropped
						REG_START: o_chk_start_addr <= AXI_ADDR_W'({i_reg_wdata[REG_DATA_W-1:BURST_LSB],
							{BURST_LSB{1'b0}}});
						REG_STOP:  o_chk_stop_addr <= AXI_ADDR_W'({i_reg_wdata[REG_DATA_W-1:BURST_LSB],
							{BURST_LSB{1'b0}}});
						REG_SEED:  o_chk_seed <= i_reg_wdata;
						default:   ;
					endcase
				end
			end
			// ack follows req down one cycle later
			else if (!i_reg_req)
				o_reg_ack <= 1'b0;
		end
	end

	// ------------------------------
	// read side
	// ------------------------------
	always_comb
	begin
		status_word                = '0;
		status_word[STAT_RUN_BIT]  = i_chk_run;
		status_word[STAT_DONE_BIT] = i_chk_done;
		status_word[STAT_FAIL_BIT] = i_chk_fail;
	end

	always_comb
	begin
		case (i_reg_addr)
			REG_START:     rd_mux = o_chk_start_addr[REG_DATA_W-1:0];
			REG_STOP:      rd_mux = o_chk_stop_addr[REG_DATA_W-1:0];
			REG_SEED:      rd_mux = o_chk_seed;
			REG_STATUS:    rd_mux = status_word;
			REG_FAIL_ADDR: rd_mux = i_chk_fail_addr[REG_DATA_W-1:0];
			REG_BURSTS:    rd_mux = i_chk_burst_count;
			// ctrl reads as zero
			default:       rd_mux = '0;
		endcase
	end

	// read data valid together with ack
	always_ff @(posedge iACLK)
	begin
		if (access && !i_reg_wr)
			o_reg_rdata <= rd_mux;
	end

endmodule

`default_nettype wire

//--- design/memory_checker.sv
`timescale 1ns/1ns
`default_nettype none

module memory_checker
	import ddr_axi_pkg::*, mem_test_pkg::*;
(
	input  wire                    iACLK,
	input  wire                    iARST,
	// test setup
	input  wire                    i_start,
	input  wire [AXI_ADDR_W-1:0]   i_start_addr,
	input  wire [AXI_ADDR_W-1:0]   i_stop_addr,
	input  wire [SEED_W-1:0]       i_seed,
	// test status
	output logic                   o_run,
	output logic                   o_done,
	output logic                   o_fail,
	output logic [AXI_ADDR_W-1:0]  o_fail_addr,
	output logic [REG_DATA_W-1:0]  o_burst_count,
	// write address
	output logic [AXI_ADDR_W-1:0]  o_awaddr,
	output logic                   o_awvalid,
	input  wire                    i_awready,
	// write data
	output logic [AXI_DATA_W-1:0]  o_wdata,
	output logic                   o_wlast,
	output logic                   o_wvalid,
	input  wire                    i_wready,
	// write response
	input  wire [AXI_RESP_W-1:0]   i_bresp,
	input  wire                    i_bvalid,
	output logic                   o_bready,
	// read address
	output logic [AXI_ADDR_W-1:0]  o_araddr,
	output logic                   o_arvalid,
	input  wire                    i_arready,
	// read data
	input  wire [AXI_DATA_W-1:0]   i_rdata,
	input  wire [AXI_RESP_W-1:0]   i_rresp,
	input  wire                    i_rlast,
	input  wire                    i_rvalid,
	output logic                   o_rready
);

	// ------------------------------
	// states
	// ------------------------------
	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_WADDR = 3'd1;
	localparam logic [2:0] ST_WDATA = 3'd2;
	localparam logic [2:0] ST_WRESP = 3'd3;
	localparam logic [2:0] ST_RADDR = 3'd4;
	localparam logic [2:0] ST_RDATA = 3'd5;
	localparam logic [2:0] ST_DONE  = 3'd6;

	logic [2:0]            state;
	ddr_addr_t             burst_addr;
	logic [BEAT_CNT_W-1:0] beat_cnt;
	logic                  burst_err;
	// setup latched at start
	logic [AXI_ADDR_W-1:0] start_q;
	logic [AXI_ADDR_W-1:0] stop_q;
	logic [SEED_W-1:0]     seed_q;
	// derived
	logic                  accept;
	logic [AXI_ADDR_W-1:0] beat_addr;
	logic [AXI_ADDR_W-1:0] next_addr;
	logic                  last_burst;
	logic [AXI_DATA_W-1:0] exp_data;
	logic                  beat_bad;

	// new test only from idle or done
	assign accept = i_start && ((state == ST_IDLE) || (state == ST_DONE));

	// byte address of current beat
	assign beat_addr  = burst_addr.flat + (AXI_ADDR_W'(beat_cnt) << BEAT_LSB);
	assign next_addr  = burst_addr.flat + AXI_ADDR_W'(BURST_BYTES);
	// stop address is exclusive
	assign last_burst = (next_addr >= stop_q);

	// pattern word, same rule for write and compare
	assign exp_data = {beat_addr[PAT_HALF_W-1:0] ^ seed_q, ~beat_addr[PAT_HALF_W-1:0]};
	// bad data or bad response
	assign beat_bad = (i_rdata != exp_data) || (i_rresp != RESP_OKAY);

	// ------------------------------
	// bus outputs
	// ------------------------------
	// all from registered state, stable until handshake
	assign o_awaddr  = burst_addr.flat;
	assign o_awvalid = (state == ST_WADDR);
	assign o_wdata   = exp_data;
	assign o_wlast   = (beat_cnt == BEAT_CNT_W'(BURST_BEATS - 1));
	assign o_wvalid  = (state == ST_WDATA);
	assign o_bready  = (state == ST_WRESP);
	assign o_araddr  = burst_addr.flat;
	assign o_arvalid = (state == ST_RADDR);
	// rready held over the whole read phase
	assign o_rready  = (state == ST_RADDR) || (state == ST_RDATA);

	assign o_run  = (state != ST_IDLE) && (state != ST_DONE);
	assign o_done = (state == ST_DONE);

	always_ff @(posedge iACLK)
	begin
		if (accept)
		begin
			start_q <= i_start_addr;
			stop_q  <= i_stop_addr;
			seed_q  <= i_seed;
		end
	end

	// ------------------------------
	// main FSM
	// ------------------------------
	always_ff @(posedge iACLK)
	begin
		if (iARST)
		begin
			state         <= ST_IDLE;
			burst_addr    <= '0;
			beat_cnt      <= '0;
			burst_err     <= 1'b0;
			o_fail        <= 1'b0;
			o_fail_addr   <= '0;
			o_burst_count <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE, ST_DONE:
				begin
					if (accept)
					begin
						burst_addr.flat <= i_start_addr;
						beat_cnt        <= '0;
						burst_err       <= 1'b0;
						o_fail          <= 1'b0;
						o_fail_addr     <= '0;
						o_burst_count   <= '0;
						// empty region, nothing to do
						state           <= (i_start_addr >= i_stop_addr) ? ST_DONE : ST_WADDR;
					end
				end

				ST_WADDR:
				begin
					if (i_awready)
						state <= ST_WDATA;
				end

				ST_WDATA:
				begin
					if (i_wready)
					begin
						if (o_wlast)
						begin
							beat_cnt <= '0;
							state    <= ST_WRESP;
						end
						else
							beat_cnt <= beat_cnt + 1'b1;
					end
				end

				ST_WRESP:
				begin
					if (i_bvalid)
					begin
						// write error, report the burst base
						if (i_bresp != RESP_OKAY)
						begin
							o_fail      <= 1'b1;
							o_fail_addr <= burst_addr.flat;
							state       <= ST_DONE;
						end
						// region written, rewind for read back
						else if (last_burst)
						begin
							burst_addr.flat <= start_q;
							state           <= ST_RADDR;
						end
						else
						begin
							burst_addr.flat <= next_addr;
							state           <= ST_WADDR;
						end
					end
				end

				ST_RADDR:
				begin
					if (i_arready)
						state <= ST_RDATA;
				end

				ST_RDATA:
				begin
					if (i_rvalid)
					begin
						beat_cnt <= i_rlast ? '0 : beat_cnt + 1'b1;
						// keep first bad beat, drain the rest
						if (beat_bad && !burst_err)
						begin
							burst_err   <= 1'b1;
							o_fail_addr <= beat_addr;
						end
						if (i_rlast)
						begin
							// failing burst counts too
							o_burst_count <= o_burst_count + 1'b1;
							burst_err     <= 1'b0;
							if (burst_err || beat_bad)
							begin
								o_fail <= 1'b1;
								state  <= ST_DONE;
							end
							else if (last_burst)
								state <= ST_DONE;
							else
							begin
								burst_addr.flat <= next_addr;
								state           <= ST_RADDR;
							end
						end
					end
				end

				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/mem_test_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_test_top
	import ddr_axi_pkg::*, mem_test_pkg::*;
(
	input  wire                    iACLK,
	input  wire                    iARST,
	input  wire                    i_cfg_done,
	// register port
	input  wire                    i_reg_req,
	input  wire                    i_reg_wr,
	input  wire [REG_ADDR_W-1:0]   i_reg_addr,
	input  wire [REG_DATA_W-1:0]   i_reg_wdata,
	output logic                   o_reg_ack,
	output logic [REG_DATA_W-1:0]  o_reg_rdata,
	// AXI4 master
	output logic [AXI_ADDR_W-1:0]  o_awaddr,
	output logic                   o_awvalid,
	input  wire                    i_awready,
	output logic [AXI_DATA_W-1:0]  o_wdata,
	output logic                   o_wlast,
	output logic                   o_wvalid,
	input  wire                    i_wready,
	input  wire [AXI_RESP_W-1:0]   i_bresp,
	input  wire                    i_bvalid,
	output logic                   o_bready,
	output logic [AXI_ADDR_W-1:0]  o_araddr,
	output logic                   o_arvalid,
	input  wire                    i_arready,
	input  wire [AXI_DATA_W-1:0]   i_rdata,
	input  wire [AXI_RESP_W-1:0]   i_rresp,
	input  wire                    i_rlast,
	input  wire                    i_rvalid,
	output logic                   o_rready,
	// test status pins
	output logic                   o_test_run,
	output logic                   o_test_done,
	output logic                   o_test_fail
);

	// ------------------------------
	// regs to checker
	// ------------------------------
	logic                  chk_start;
	logic [AXI_ADDR_W-1:0] chk_start_addr;
	logic [AXI_ADDR_W-1:0] chk_stop_addr;
	logic [SEED_W-1:0]     chk_seed;
	// checker back to regs
	logic [AXI_ADDR_W-1:0] chk_fail_addr;
	logic [REG_DATA_W-1:0] chk_burst_count;

	mem_test_regs u_regs (
		.iACLK             (iACLK),
		.iARST             (iARST),
		.i_cfg_done        (i_cfg_done),
		.i_reg_req         (i_reg_req),
		.i_reg_wr          (i_reg_wr),
		.i_reg_addr        (i_reg_addr),
		.i_reg_wdata       (i_reg_wdata),
		.o_reg_ack         (o_reg_ack),
		.o_reg_rdata       (o_reg_rdata),
		.o_chk_start       (chk_start),
		.o_chk_start_addr  (chk_start_addr),
		.o_chk_stop_addr   (chk_stop_addr),
		.o_chk_seed        (chk_seed),
		.i_chk_run         (o_test_run),
		.i_chk_done        (o_test_done),
		.i_chk_fail        (o_test_fail),
		.i_chk_fail_addr   (chk_fail_addr),
		.i_chk_burst_count (chk_burst_count)
	);

	// status pins come straight off the checker
	memory_checker u_checker (
		.iACLK         (iACLK),
		.iARST         (iARST),
		.i_start       (chk_start),
		.i_start_addr  (chk_start_addr),
		.i_stop_addr   (chk_stop_addr),
		.i_seed        (chk_seed),
		.o_run         (o_test_run),
		.o_done        (o_test_done),
		.o_fail        (o_test_fail),
		.o_fail_addr   (chk_fail_addr),
		.o_burst_count (chk_burst_count),
		.o_awaddr      (o_awaddr),
		.o_awvalid     (o_awvalid),
		.i_awready     (i_awready),
		.o_wdata       (o_wdata),
		.o_wlast       (o_wlast),
		.o_wvalid      (o_wvalid),
		.i_wready      (i_wready),
		.i_bresp       (i_bresp),
		.i_bvalid      (i_bvalid),
		.o_bready      (o_bready),
		.o_araddr      (o_araddr),
		.o_arvalid     (o_arvalid),
		.i_arready     (i_arready),
		.i_rdata       (i_rdata),
		.i_rresp       (i_rresp),
		.i_rlast       (i_rlast),
		.i_rvalid      (i_rvalid),
		.o_rready      (o_rready)
	);

endmodule

`default_nettype wire

//--- verif/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model
	import ddr_axi_pkg::*;
(
	input  wire                   iACLK,
	input  wire                   iARST,
	// single-bit fault on one beat address
	input  wire                   i_fault_en,
	input  wire [AXI_ADDR_W-1:0]  i_fault_addr,
	// write side
	input  wire [AXI_ADDR_W-1:0]  i_awaddr,
	input  wire                   i_awvalid,
	output logic                  o_awready,
	input  wire [AXI_DATA_W-1:0]  i_wdata,
	input  wire                   i_wlast,
	input  wire                   i_wvalid,
	output logic                  o_wready,
	output logic [AXI_RESP_W-1:0] o_bresp,
	output logic                  o_bvalid,
	input  wire                   i_bready,
	// read side
	input  wire [AXI_ADDR_W-1:0]  i_araddr,
	input  wire                   i_arvalid,
	output logic                  o_arready,
	output logic [AXI_DATA_W-1:0] o_rdata,
	output logic [AXI_RESP_W-1:0] o_rresp,
	output logic                  o_rlast,
	output logic                  o_rvalid,
	input  wire                   i_rready
);

	// array indexed by bank, low row bits and column
	localparam int          ROW_LO_W = 3;
	localparam int          IDX_W    = DDR_BANK_W + ROW_LO_W + DDR_COL_W;
	localparam logic [31:0] LCG_SEED = 32'd22;

	logic [AXI_DATA_W-1:0] mem [0:(1<<IDX_W)-1];
	logic [31:0]           lcg;
	logic                  wr_busy;
	logic                  rd_busy;
	logic [AXI_ADDR_W-1:0] wr_addr;
	logic [AXI_ADDR_W-1:0] rd_addr;
	logic [2:0]            rd_cnt;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [IDX_W-1:0] mem_index(input logic [AXI_ADDR_W-1:0] a);
		ddr_addr_t u;
		u.flat = a;
		return {u.fld.bank, u.fld.row[ROW_LO_W-1:0], u.fld.col};
	endfunction

	// never an error response
	assign o_bresp = RESP_OKAY;
	assign o_rresp = RESP_OKAY;

	always_ff @(posedge iACLK)
	begin
		if (iARST)
		begin
			lcg       <= LCG_SEED;
			wr_busy   <= 1'b0;
			rd_busy   <= 1'b0;
			wr_addr   <= '0;
			rd_addr   <= '0;
			rd_cnt    <= '0;
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			o_bvalid  <= 1'b0;
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
			o_rlast   <= 1'b0;
			o_rdata   <= '0;
		end
		else
		begin
			lcg <= lcg_next(lcg);
			// ------------------------------
			// write path, ready about 3 of 4 cycles
			// ------------------------------
			if (i_awvalid && o_awready)
			begin
				wr_busy   <= 1'b1;
				wr_addr   <= i_awaddr;
				o_awready <= 1'b0;
			end
			else
				o_awready <= !wr_busy && (lcg[17:16] != 2'b00);
			if (i_wvalid && o_wready)
			begin
				// flip bit 0 of the faulty word on its way in
				if (i_fault_en && (wr_addr == i_fault_addr))
					mem[mem_index(wr_addr)] <= i_wdata ^ AXI_DATA_W'(1);
				else
					mem[mem_index(wr_addr)] <= i_wdata;
				wr_addr <= wr_addr + AXI_ADDR_W'(AXI_STRB_W);
				if (i_wlast)
				begin
					o_wready <= 1'b0;
					o_bvalid <= 1'b1;
				end
				else
					o_wready <= (lcg[19:18] != 2'b00);
			end
			else
				o_wready <= wr_busy && !o_bvalid && (lcg[19:18] != 2'b00);
			if (o_bvalid && i_bready)
			begin
				o_bvalid <= 1'b0;
				wr_busy  <= 1'b0;
			end
			// ------------------------------
			// read path, random gaps between beats
			// ------------------------------
			if (i_arvalid && o_arready)
			begin
				rd_busy   <= 1'b1;
				rd_addr   <= i_araddr;
				rd_cnt    <= '0;
				o_arready <= 1'b0;
			end
			else
				o_arready <= !rd_busy && (lcg[21:20] != 2'b00);
			// beat slot free when empty or just taken
			if (rd_busy && (!o_rvalid || i_rready))
			begin
				if (o_rvalid && o_rlast)
				begin
					o_rvalid <= 1'b0;
					o_rlast  <= 1'b0;
					rd_busy  <= 1'b0;
				end
				else if (lcg[23:22] != 2'b00)
				begin
					o_rvalid <= 1'b1;
					o_rdata  <= mem[mem_index(rd_addr)];
					o_rlast  <= (rd_cnt == 3'(BURST_BEATS - 1));
					rd_addr  <= rd_addr + AXI_ADDR_W'(AXI_STRB_W);
					rd_cnt   <= rd_cnt + 3'd1;
				end
				else
					o_rvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_mem_test.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_test
	import ddr_axi_pkg::*, mem_test_pkg::*;
();

	localparam int NUM_ROWS         = 5;
	localparam int RESET_CYCLES     = 16;
	// idle time for rows that never start
	localparam int IDLE_WINDOW      = 200;
	localparam int CYCLES_PER_BURST = 40;
	localparam int ROW_MARGIN       = 600;

	logic                  clk;
	logic                  rst;
	logic                  cfg_done;
	logic                  reg_req;
	logic                  reg_wr;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [REG_DATA_W-1:0] reg_wdata;
	logic                  reg_ack;
	logic [REG_DATA_W-1:0] reg_rdata;
	logic                  fault_en;
	logic [AXI_ADDR_W-1:0] fault_addr;
	// AXI between DUT and memory
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic                  wlast;
	logic                  wvalid;
	logic                  wready;
	logic [AXI_RESP_W-1:0] bresp;
	logic                  bvalid;
	logic                  bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [AXI_RESP_W-1:0] rresp;
	logic                  rlast;
	logic                  rvalid;
	logic                  rready;
	logic                  test_run;
	logic                  test_done;
	logic                  test_fail;

	// ------------------------------
	// stimulus and expected table
	// ------------------------------
	string       row_name          [NUM_ROWS];
	logic        row_cfg           [NUM_ROWS];
	logic [31:0] row_start         [NUM_ROWS];
	logic [31:0] row_stop          [NUM_ROWS];
	logic [31:0] row_seed          [NUM_ROWS];
	logic        row_fault_en      [NUM_ROWS];
	logic [31:0] row_fault_addr    [NUM_ROWS];
	logic        row_exp_fail      [NUM_ROWS];
	logic [31:0] row_exp_fail_addr [NUM_ROWS];
	int          row_exp_bursts    [NUM_ROWS];

	bit table_loaded = 1'b0;
	int error_count  = 0;

	// burst tracking for the bus monitor
	int                    cur_row = 0;
	logic [AXI_ADDR_W-1:0] aw_next;
	logic [AXI_ADDR_W-1:0] ar_next;
	logic [AXI_ADDR_W-1:0] w_addr;
	int                    w_beat;

	mem_test_top dut0 (
		.iACLK       (clk),
		.iARST       (rst),
		.i_cfg_done  (cfg_done),
		.i_reg_req   (reg_req),
		.i_reg_wr    (reg_wr),
		.i_reg_addr  (reg_addr),
		.i_reg_wdata (reg_wdata),
		.o_reg_ack   (reg_ack),
		.o_reg_rdata (reg_rdata),
		.o_awaddr    (awaddr),
		.o_awvalid   (awvalid),
		.i_awready   (awready),
		.o_wdata     (wdata),
		.o_wlast     (wlast),
		.o_wvalid    (wvalid),
		.i_wready    (wready),
		.i_bresp     (bresp),
		.i_bvalid    (bvalid),
		.o_bready    (bready),
		.o_araddr    (araddr),
		.o_arvalid   (arvalid),
		.i_arready   (arready),
		.i_rdata     (rdata),
		.i_rresp     (rresp),
		.i_rlast     (rlast),
		.i_rvalid    (rvalid),
		.o_rready    (rready),
		.o_test_run  (test_run),
		.o_test_done (test_done),
		.o_test_fail (test_fail)
	);

	axi_mem_model mem0 (
		.iACLK        (clk),
		.iARST        (rst),
		.i_fault_en   (fault_en),
		.i_fault_addr (fault_addr),
		.i_awaddr     (awaddr),
		.i_awvalid    (awvalid),
		.o_awready    (awready),
		.i_wdata      (wdata),
		.i_wlast      (wlast),
		.i_wvalid     (wvalid),
		.o_wready     (wready),
		.o_bresp      (bresp),
		.o_bvalid     (bvalid),
		.i_bready     (bready),
		.i_araddr     (araddr),
		.i_arvalid    (arvalid),
		.o_arready    (arready),
		.o_rdata      (rdata),
		.o_rresp      (rresp),
		.o_rlast      (rlast),
		.o_rvalid     (rvalid),
		.i_rready     (rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// low address bits below one burst are dropped
	function automatic logic [31:0] burst_align(input logic [31:0] a);
		return a & ~32'(BURST_BYTES - 1);
	endfunction

	// upper half is address xor seed, lower half the inverted address
	function automatic logic [AXI_DATA_W-1:0] pattern_word(input logic [AXI_ADDR_W-1:0] a,
		input logic [31:0] seed);
		return {a[31:0] ^ seed, ~a[31:0]};
	endfunction

	task automatic set_row(input int i, input string name, input logic cfg,
		input logic [31:0] start, input logic [31:0] stop, input logic [31:0] seed,
		input logic fen, input logic [31:0] faddr, input logic efail,
		input logic [31:0] efaddr, input int ebursts);
		row_name[i]          = name;
		row_cfg[i]           = cfg;
		row_start[i]         = start;
		row_stop[i]          = stop;
		row_seed[i]          = seed;
		row_fault_en[i]      = fen;
		row_fault_addr[i]    = faddr;
		row_exp_fail[i]      = efail;
		row_exp_fail_addr[i] = efaddr;
		row_exp_bursts[i]    = ebursts;
	endtask

	// clean rows expect (stop-start)/32 bursts
	// fault rows expect (fault-start)/32 + 1
	task automatic load_table();
		set_row(0, "clean_region", 1'b1, 32'h0000, 32'h0400, 32'h1234_5678,
			1'b0, 32'h0, 1'b0, 32'h0, 32);
		set_row(1, "bit_fault", 1'b1, 32'h1000, 32'h1400, 32'hA5A5_0F0F,
			1'b1, 32'h1128, 1'b1, 32'h1128, 10);
		// unaligned setup that lands on 0x2000 up to 0x2800
		set_row(2, "stall_seed", 1'b1, 32'h2011, 32'h281F, 32'hDEAD_BEEF,
			1'b0, 32'h0, 1'b0, 32'h0, 64);
		set_row(3, "no_cfg_done", 1'b0, 32'h3000, 32'h3100, 32'h0BAD_F00D,
			1'b0, 32'h0, 1'b0, 32'h0, 0);
		set_row(4, "fault_first_beat", 1'b1, 32'h4000, 32'h4100, 32'h0000_0001,
			1'b1, 32'h4000, 1'b1, 32'h4000, 1);
	endtask

	// ------------------------------
	// four phase register port
	// ------------------------------
	task automatic reg_write(input logic [REG_ADDR_W-1:0] a, input logic [REG_DATA_W-1:0] d);
		@(posedge clk);
		reg_req   <= 1'b1;
		reg_wr    <= 1'b1;
		reg_addr  <= a;
		reg_wdata <= d;
		@(posedge clk);
		while (reg_ack !== 1'b1)
			@(posedge clk);
		reg_req <= 1'b0;
		@(posedge clk);
		while (reg_ack !== 1'b0)
			@(posedge clk);
	endtask

	task automatic reg_read(input logic [REG_ADDR_W-1:0] a, output logic [REG_DATA_W-1:0] d);
		@(posedge clk);
		reg_req  <= 1'b1;
		reg_wr   <= 1'b0;
		reg_addr <= a;
		@(posedge clk);
		while (reg_ack !== 1'b1)
			@(posedge clk);
		// rdata registered on the ack edge
		d       = reg_rdata;
		reg_req <= 1'b0;
		@(posedge clk);
		while (reg_ack !== 1'b0)
			@(posedge clk);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst      <= 1'b1;
		cfg_done <= 1'b0;
		fault_en <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
	endtask

	task automatic run_row(input int r);
		logic [REG_DATA_W-1:0] rd;
		logic [REG_DATA_W-1:0] exp_status;
		cur_row                   = r;
		exp_status                = '0;
		exp_status[STAT_DONE_BIT] = row_cfg[r];
		exp_status[STAT_FAIL_BIT] = row_exp_fail[r];
		apply_reset();
		// quiet after reset
		if (test_run || test_done || test_fail || reg_ack || awvalid || wvalid || bready ||
			arvalid || rready)
		begin
			$display("Fail %s: a status, ack or bus output is high after reset", row_name[r]);
			error_count++;
		end
		reg_read(REG_STATUS, rd);
		if (rd !== 32'h0)
		begin
			$display("Fail %s status_after_reset: expected %h, actual %h", row_name[r], 32'h0, rd);
			error_count++;
		end
		@(posedge clk);
		cfg_done   <= row_cfg[r];
		fault_en   <= row_fault_en[r];
		fault_addr <= AXI_ADDR_W'(row_fault_addr[r]);
		reg_write(REG_START, row_start[r]);
		reg_write(REG_STOP, row_stop[r]);
		reg_write(REG_SEED, row_seed[r]);
		// read back setup
		reg_read(REG_START, rd);
		if (rd !== burst_align(row_start[r]))
		begin
			$display("Fail %s start_readback: expected %h, actual %h", row_name[r],
				burst_align(row_start[r]), rd);
			error_count++;
		end
		reg_read(REG_STOP, rd);
		if (rd !== burst_align(row_stop[r]))
		begin
			$display("Fail %s stop_readback: expected %h, actual %h", row_name[r],
				burst_align(row_stop[r]), rd);
			error_count++;
		end
		reg_read(REG_SEED, rd);
		if (rd !== row_seed[r])
		begin
			$display("Fail %s seed_readback: expected %h, actual %h", row_name[r],
				row_seed[r], rd);
			error_count++;
		end
		reg_write(REG_CTRL, REG_DATA_W'(1) << CTRL_START_BIT);
		if (row_cfg[r])
		begin
			if (test_run !== 1'b1)
			begin
				$display("Fail %s: run did not rise after the start write", row_name[r]);
				error_count++;
			end
			// poll status until done
			reg_read(REG_STATUS, rd);
			while (!rd[STAT_DONE_BIT])
				reg_read(REG_STATUS, rd);
		end
		else
		begin
			repeat (IDLE_WINDOW) @(posedge clk);
			reg_read(REG_STATUS, rd);
		end
		// ------------------------------
		// results
		// ------------------------------
		if (rd !== exp_status)
		begin
			$display("Fail %s status: expected %h, actual %h", row_name[r], exp_status, rd);
			error_count++;
		end
		if ((test_run !== 1'b0) || (test_done !== row_cfg[r]) || (test_fail !== row_exp_fail[r]))
		begin
			$display("Fail %s status_ports: expected %b%b%b, actual %b%b%b", row_name[r],
				row_exp_fail[r], row_cfg[r], 1'b0, test_fail, test_done, test_run);
			error_count++;
		end
		reg_read(REG_FAIL_ADDR, rd);
		if (rd !== row_exp_fail_addr[r])
		begin
			$display("Fail %s fail_addr: expected %h, actual %h", row_name[r],
				row_exp_fail_addr[r], rd);
			error_count++;
		end
		reg_read(REG_BURSTS, rd);
		if (rd !== 32'(row_exp_bursts[r]))
		begin
			$display("Fail %s burst_count: expected %0d, actual %0d", row_name[r],
				row_exp_bursts[r], rd);
			error_count++;
		end
	endtask

	// ------------------------------
	// bus monitor
	// ------------------------------
	// bursts step by 32 from the aligned start address
	always @(posedge clk)
	begin
		if (rst)
		begin
			aw_next <= AXI_ADDR_W'(burst_align(row_start[cur_row]));
			ar_next <= AXI_ADDR_W'(burst_align(row_start[cur_row]));
			w_addr  <= '0;
			w_beat  <= 0;
		end
		else
		begin
			if (awvalid && awready)
			begin
				if (awaddr !== aw_next)
				begin
					$display("Fail %s awaddr: expected %h, actual %h", row_name[cur_row],
						aw_next, awaddr);
					error_count++;
				end
				aw_next <= aw_next + AXI_ADDR_W'(BURST_BYTES);
				w_addr  <= awaddr;
			end
			// every written beat must follow the pattern rule
			if (wvalid && wready)
			begin
				if (wdata !== pattern_word(w_addr, row_seed[cur_row]))
				begin
					$display("Fail %s wdata: expected %h, actual %h", row_name[cur_row],
						pattern_word(w_addr, row_seed[cur_row]), wdata);
					error_count++;
				end
				if (wlast !== (w_beat == BURST_BEATS - 1))
				begin
					$display("Fail %s wlast: expected %b, actual %b", row_name[cur_row],
						(w_beat == BURST_BEATS - 1), wlast);
					error_count++;
				end
				w_addr <= w_addr + AXI_ADDR_W'(AXI_STRB_W);
				w_beat <= (w_beat == BURST_BEATS - 1) ? 0 : w_beat + 1;
			end
			if (arvalid && arready)
			begin
				if (araddr !== ar_next)
				begin
					$display("Fail %s araddr: expected %h, actual %h", row_name[cur_row],
						ar_next, araddr);
					error_count++;
				end
				ar_next <= ar_next + AXI_ADDR_W'(BURST_BYTES);
			end
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		int r;
		rst        = 1'b1;
		cfg_done   = 1'b0;
		reg_req    = 1'b0;
		reg_wr     = 1'b0;
		reg_addr   = '0;
		reg_wdata  = '0;
		fault_en   = 1'b0;
		fault_addr = '0;
		load_table();
		table_loaded = 1'b1;
		for (r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("rows run %0d, errors %0d", NUM_ROWS, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// limit grows with the number of bursts in the table
	initial
	begin
		longint limit;
		int     i;
		wait (table_loaded);
		limit = 0;
		for (i = 0; i < NUM_ROWS; i++)
			limit += (burst_align(row_stop[i]) - burst_align(row_start[i])) / BURST_BYTES *
				CYCLES_PER_BURST + ROW_MARGIN;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
design/ddr_axi_pkg.sv
design/mem_test_pkg.sv
design/mem_test_regs.sv
design/memory_checker.sv
design/mem_test_top.sv
verif/axi_mem_model.sv
verif/tb_mem_test.sv

//--- Makefile
# Verilator build and run for the memory tester testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_test
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	@if grep -qx "All tests passed" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
